//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_obi_integrity_unit
RTL_TOP   ?= obi_integrity_unit
FILELIST  ?= obi_integrity_unit.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= obi_integrity_pkg.sv obi_integrity_ifs.sv obi_req_encoder.sv \
             obi_txn_tracker.sv obi_resp_checker.sv obi_alert_ctrl.sv obi_integrity_unit.sv
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)

//--- obi_alert_ctrl.sv
// Integrity enable and major alert
`timescale 1ns/1ps
`default_nettype none

module obi_alert_ctrl (
  input  wire logic clk_i,
  input  wire logic rst,
  input  wire logic csr_we,
  input  wire logic csr_wdata,
  output logic      integrity_enabled,
  input  wire logic gnt_par_fault,
  input  wire logic rvalid_par_fault,
  input  wire logic rchk_fault,
  output logic      alert_major
);

  logic enable_q;
  logic alert_q;

  // Checking is on out of reset
  always_ff @(posedge clk_i) begin
    if (rst) begin
      enable_q <= 1'b1;
    end else if (csr_we) begin
      enable_q <= csr_wdata;
    end
  end

  // One alert cycle for every faulty cycle
  always_ff @(posedge clk_i) begin
    if (rst) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= gnt_par_fault | rvalid_par_fault | rchk_fault;
    end
  end

  assign integrity_enabled = enable_q;
  assign alert_major       = alert_q;

endmodule

`default_nettype wire

//--- obi_integrity_ifs.sv
// Internal interfaces of the integrity unit
`timescale 1ns/1ps
`default_nettype none

// Encoder to tracker, record push and credit state
interface credit_if;
  logic                        push;
  obi_integrity_pkg::txn_rec_t rec;
  logic                        credit_avail;
  logic                        ack_rec;

  modport encoder (
    output push, rec,
    input  credit_avail, ack_rec
  );

  modport tracker (
    input  push, rec,
    output credit_avail, ack_rec
  );
endinterface

// Tracker to checker, head record and response pop
interface resp_if;
  logic                        head_valid;
  obi_integrity_pkg::txn_rec_t head_rec;
  logic                        pop;
  logic                        free_pop;

  modport tracker (
    output head_valid, head_rec, free_pop,
    input  pop
  );

  modport chk (
    input  head_valid, head_rec, free_pop,
    output pop
  );
endinterface

`default_nettype wire

//--- obi_integrity_pkg.sv
// OBI data port integrity definitions
`default_nettype none

package obi_integrity_pkg;

  // Bus field widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = 4;
  localparam int unsigned PROT_W    = 3;
  localparam int unsigned MEMTYPE_W = 2;
  localparam int unsigned ATOP_W    = 6;
  localparam int unsigned MID_W     = 8;

  // Checksum widths and the rchk bit that covers err and exokay
  localparam int unsigned ACHK_W       = 13;
  localparam int unsigned RCHK_W       = 5;
  localparam int unsigned RCHK_ERR_BIT = 4;

  // Number of bytes covered by one parity bit group
  localparam int unsigned WORD_BYTES = 4;

  // Credits, i.e. depth of the outstanding transaction FIFO
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned OUTST_CNT_W     = 2;
  localparam int unsigned TRK_PTR_W       = 1;

  // One record per granted request
  typedef struct packed {
    logic is_store;
    logic gnt_par_err;
    logic had_integrity;
  } txn_rec_t;

  // Even parity of each byte of a word, high byte first
  function automatic logic [WORD_BYTES-1:0] byte_par(input logic [DATA_W-1:0] word);
    logic [WORD_BYTES-1:0] par;
    for (int unsigned i = 0; i < WORD_BYTES; i++) begin
      par[i] = ^word[8*i +: 8];
    end
    return par;
  endfunction

endpackage

`default_nettype wire

//--- obi_integrity_stim.txt
// Columns: op addr wdata be rdata err enable inject, all hex, one transaction per line
// op 0 load 1 store, inject 0 none 1 bad_rchk 2 bad_gntpar 3 bad_rvalidpar
0 00001000 00000000 f a5a5f00f 0 1 0
1 00001004 12345678 f 00000000 0 1 0
0 00001008 00000000 3 80000001 0 1 1
1 0000100c cafef00d c 00000000 0 1 1
0 00001010 00000000 f 0badc0de 0 0 1
0 00001014 00000000 f 13579bdf 0 1 2
1 00001018 deadbeef 1 00000000 0 0 2
0 0000101c 00000000 f 2468ace0 0 1 3
1 00001020 0f0f0f0f f 00000000 0 0 3
0 00001024 00000000 f ffff0000 1 1 0
1 00001028 11223344 6 00000000 1 1 0
0 8000002c 00000000 f 7e7e7e7e 0 0 0
1 0000a030 55aa55aa f 00000000 0 1 1
0 00001034 00000000 f 01020304 1 1 1

//--- obi_integrity_unit.f
obi_integrity_pkg.sv
obi_integrity_ifs.sv
obi_req_encoder.sv
obi_txn_tracker.sv
obi_resp_checker.sv
obi_alert_ctrl.sv
obi_integrity_unit.sv
obi_integrity_unit_asserts.sv
tb_obi_integrity_unit.sv

//--- obi_integrity_unit.sv
// OBI data port integrity unit
`timescale 1ns/1ps
`default_nettype none

module obi_integrity_unit (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst,
  // Core side
  input  wire logic                                    core_req,
  input  wire logic [obi_integrity_pkg::ADDR_W-1:0]    core_addr,
  input  wire logic [obi_integrity_pkg::DATA_W-1:0]    core_wdata,
  input  wire logic [obi_integrity_pkg::BE_W-1:0]      core_be,
  input  wire logic                                    core_we,
  input  wire logic                                    core_dbg,
  input  wire logic [obi_integrity_pkg::PROT_W-1:0]    core_prot,
  input  wire logic [obi_integrity_pkg::MEMTYPE_W-1:0] core_memtype,
  output logic                                         core_ready,
  output logic                                         core_rvalid,
  output logic [obi_integrity_pkg::DATA_W-1:0]         core_rdata,
  output logic                                         core_err,
  output logic                                         core_integrity_err,
  // Bus address phase
  output logic                                         obi_req,
  output logic                                         obi_reqpar,
  output logic [obi_integrity_pkg::ACHK_W-1:0]         obi_achk,
  output logic [obi_integrity_pkg::ADDR_W-1:0]         obi_addr,
  output logic [obi_integrity_pkg::DATA_W-1:0]         obi_wdata,
  output logic [obi_integrity_pkg::BE_W-1:0]           obi_be,
  output logic                                         obi_we,
  output logic                                         obi_dbg,
  output logic [obi_integrity_pkg::PROT_W-1:0]         obi_prot,
  output logic [obi_integrity_pkg::MEMTYPE_W-1:0]      obi_memtype,
  input  wire logic                                    obi_gnt,
  input  wire logic                                    obi_gntpar,
  // Bus response phase
  input  wire logic                                    obi_rvalid,
  input  wire logic                                    obi_rvalidpar,
  input  wire logic [obi_integrity_pkg::DATA_W-1:0]    obi_rdata,
  input  wire logic                                    obi_err,
  input  wire logic                                    obi_exokay,
  input  wire logic [obi_integrity_pkg::RCHK_W-1:0]    obi_rchk,
  // Control and alert
  input  wire logic                                    csr_we,
  input  wire logic                                    csr_wdata,
  output logic                                         integrity_enabled,
  output logic                                         alert_major
);

  logic gnt_par_fault;
  logic rvalid_par_fault;
  logic rchk_fault;

  credit_if i_credit_if ();
  resp_if   i_resp_if ();

  // Address phase fields go to the bus unchanged
  assign obi_addr    = core_addr;
  assign obi_wdata   = core_wdata;
  assign obi_be      = core_be;
  assign obi_we      = core_we;
  assign obi_dbg     = core_dbg;
  assign obi_prot    = core_prot;
  assign obi_memtype = core_memtype;

  obi_req_encoder i_obi_req_encoder (
    .clk_i             (clk_i),
    .rst               (rst),
    .core_req          (core_req),
    .core_addr         (core_addr),
    .core_wdata        (core_wdata),
    .core_be           (core_be),
    .core_we           (core_we),
    .core_dbg          (core_dbg),
    .core_prot         (core_prot),
    .core_memtype      (core_memtype),
    .core_ready        (core_ready),
    .obi_req           (obi_req),
    .obi_reqpar        (obi_reqpar),
    .obi_achk          (obi_achk),
    .obi_gnt           (obi_gnt),
    .obi_gntpar        (obi_gntpar),
    .integrity_enabled (integrity_enabled),
    .credit            (i_credit_if.encoder),
    .gnt_par_fault     (gnt_par_fault)
  );

  obi_txn_tracker i_obi_txn_tracker (
    .clk_i  (clk_i),
    .rst    (rst),
    .credit (i_credit_if.tracker),
    .resp   (i_resp_if.tracker)
  );

  obi_resp_checker i_obi_resp_checker (
    .obi_rvalid         (obi_rvalid),
    .obi_rvalidpar      (obi_rvalidpar),
    .obi_rdata          (obi_rdata),
    .obi_err            (obi_err),
    .obi_exokay         (obi_exokay),
    .obi_rchk           (obi_rchk),
    .integrity_enabled  (integrity_enabled),
    .resp               (i_resp_if.chk),
    .core_rvalid        (core_rvalid),
    .core_rdata         (core_rdata),
    .core_err           (core_err),
    .core_integrity_err (core_integrity_err),
    .rvalid_par_fault   (rvalid_par_fault),
    .rchk_fault         (rchk_fault)
  );

  obi_alert_ctrl i_obi_alert_ctrl (
    .clk_i             (clk_i),
    .rst               (rst),
    .csr_we            (csr_we),
    .csr_wdata         (csr_wdata),
    .integrity_enabled (integrity_enabled),
    .gnt_par_fault     (gnt_par_fault),
    .rvalid_par_fault  (rvalid_par_fault),
    .rchk_fault        (rchk_fault),
    .alert_major       (alert_major)
  );

endmodule

`default_nettype wire

//--- obi_integrity_unit_asserts.sv
// Bound protocol checks for the integrity unit
`timescale 1ns/1ps
`default_nettype none

module obi_integrity_unit_asserts (
  input wire logic clk_i,
  input wire logic rst,
  input wire logic obi_req,
  input wire logic obi_reqpar,
  input wire logic obi_gnt,
  input wire logic obi_rvalid,
  input wire logic alert_major
);

  localparam int CW = obi_integrity_pkg::OUTST_CNT_W + 1;

  logic [CW-1:0] outst_q;
  // Sticky, high once any property below has failed
  logic          assert_failed = 1'b0;

  // Granted requests still waiting for their response
  always_ff @(posedge clk_i) begin
    if (rst) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + CW'(obi_req & obi_gnt) - CW'(obi_rvalid);
    end
  end

  reqpar_inverse: assert property (@(posedge clk_i) disable iff (rst)
    obi_reqpar == !obi_req)
    else begin
      assert_failed = 1'b1;
      $error("obi_reqpar is not the inverse of obi_req");
    end

  credit_limit: assert property (@(posedge clk_i) disable iff (rst)
    outst_q >= CW'(obi_integrity_pkg::MAX_OUTSTANDING) |-> !obi_req)
    else begin
      assert_failed = 1'b1;
      $error("obi_req raised with all credits in use");
    end

  alert_after_reset: assert property (@(posedge clk_i) $fell(rst) |-> !alert_major)
    else begin
      assert_failed = 1'b1;
      $error("alert_major high in the first cycle after reset");
    end

endmodule

bind obi_integrity_unit obi_integrity_unit_asserts i_obi_integrity_unit_asserts (
  .clk_i       (clk_i),
  .rst         (rst),
  .obi_req     (obi_req),
  .obi_reqpar  (obi_reqpar),
  .obi_gnt     (obi_gnt),
  .obi_rvalid  (obi_rvalid),
  .alert_major (alert_major)
);

`default_nettype wire

//--- obi_req_encoder.sv
// OBI request encoder
`timescale 1ns/1ps
`default_nettype none

module obi_req_encoder (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst,
  input  wire logic                                      core_req,
  input  wire logic [obi_integrity_pkg::ADDR_W-1:0]      core_addr,
  input  wire logic [obi_integrity_pkg::DATA_W-1:0]      core_wdata,
  input  wire logic [obi_integrity_pkg::BE_W-1:0]        core_be,
  input  wire logic                                      core_we,
  input  wire logic                                      core_dbg,
  input  wire logic [obi_integrity_pkg::PROT_W-1:0]      core_prot,
  input  wire logic [obi_integrity_pkg::MEMTYPE_W-1:0]   core_memtype,
  output logic                                           core_ready,
  output logic                                           obi_req,
  output logic                                           obi_reqpar,
  output logic [obi_integrity_pkg::ACHK_W-1:0]           obi_achk,
  input  wire logic                                      obi_gnt,
  input  wire logic                                      obi_gntpar,
  input  wire logic                                      integrity_enabled,
  credit_if.encoder                                      credit,
  output logic                                           gnt_par_fault
);

  logic [obi_integrity_pkg::ATOP_W-1:0] atop;
  logic [obi_integrity_pkg::MID_W-1:0]  mid;
  logic                                 gnt_fault_seen_q;

  // Atomics and manager id are not used by this port
  assign atop = '0;
  assign mid  = '0;

  // No credit means no request on the bus
  assign obi_req    = core_req & credit.credit_avail;
  assign obi_reqpar = ~obi_req;
  assign core_ready = obi_gnt & credit.credit_avail;

  assign obi_achk = {
    obi_integrity_pkg::byte_par(core_wdata),
    ~^core_dbg,
    ^atop,
    ^mid,
    ~^{core_be, core_we},
    ~^{core_prot, core_memtype},
    obi_integrity_pkg::byte_par(core_addr)
  };

  assign gnt_par_fault = (obi_gntpar == obi_gnt);

  // Grant parity faults seen while the request waits belong to that request
  always_ff @(posedge clk_i) begin
    if (rst) begin
      gnt_fault_seen_q <= 1'b0;
    end else if (credit.ack_rec) begin
      gnt_fault_seen_q <= 1'b0;
    end else if (obi_req && gnt_par_fault) begin
      gnt_fault_seen_q <= 1'b1;
    end
  end

  assign credit.push              = obi_req & obi_gnt;
  assign credit.rec.is_store      = core_we;
  assign credit.rec.gnt_par_err   = gnt_par_fault | gnt_fault_seen_q;
  assign credit.rec.had_integrity = integrity_enabled;

endmodule

`default_nettype wire

//--- obi_resp_checker.sv
// OBI response integrity checker
`timescale 1ns/1ps
`default_nettype none

module obi_resp_checker (
  input  wire logic                                 obi_rvalid,
  input  wire logic                                 obi_rvalidpar,
  input  wire logic [obi_integrity_pkg::DATA_W-1:0] obi_rdata,
  input  wire logic                                 obi_err,
  input  wire logic                                 obi_exokay,
  input  wire logic [obi_integrity_pkg::RCHK_W-1:0] obi_rchk,
  input  wire logic                                 integrity_enabled,
  resp_if.chk                                       resp,
  output logic                                      core_rvalid,
  output logic [obi_integrity_pkg::DATA_W-1:0]      core_rdata,
  output logic                                      core_err,
  output logic                                      core_integrity_err,
  output logic                                      rvalid_par_fault,
  output logic                                      rchk_fault
);

  localparam int unsigned ERR_BIT = obi_integrity_pkg::RCHK_ERR_BIT;

  logic [obi_integrity_pkg::RCHK_W-1:0] rchk_calc;
  logic                                 rchk_mismatch;
  logic                                 gnt_err;

  assign rchk_calc = {^{obi_err, obi_exokay}, obi_integrity_pkg::byte_par(obi_rdata)};

  // Stores carry no read data, so only the err/exokay bit is meaningful
  always_comb begin
    if (resp.head_rec.is_store) begin
      rchk_mismatch = (obi_rchk[ERR_BIT] != rchk_calc[ERR_BIT]);
    end else begin
      rchk_mismatch = (obi_rchk != rchk_calc);
    end
  end

  assign resp.pop = obi_rvalid & resp.head_valid;

  assign rvalid_par_fault = (obi_rvalidpar == obi_rvalid);

  // Ignored unless enabled now and when the request went out
  assign rchk_fault = resp.free_pop & integrity_enabled & resp.head_rec.had_integrity &
                      rchk_mismatch;

  assign gnt_err = resp.free_pop & resp.head_rec.gnt_par_err;

  assign core_rvalid        = obi_rvalid;
  assign core_rdata         = obi_rdata;
  assign core_err           = obi_err;
  assign core_integrity_err = obi_rvalid & (rchk_fault | rvalid_par_fault | gnt_err);

endmodule

`default_nettype wire

//--- obi_txn_tracker.sv
// Outstanding transaction tracker
`timescale 1ns/1ps
`default_nettype none

module obi_txn_tracker (
  input  wire logic clk_i,
  input  wire logic rst,
  credit_if.tracker credit,
  resp_if.tracker   resp
);

  localparam int unsigned DEPTH = obi_integrity_pkg::MAX_OUTSTANDING;
  localparam int unsigned PTR_W = obi_integrity_pkg::TRK_PTR_W;
  localparam int unsigned CNT_W = obi_integrity_pkg::OUTST_CNT_W;

  obi_integrity_pkg::txn_rec_t mem [DEPTH];

  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  assign credit.credit_avail = (count_q < CNT_W'(DEPTH));
  assign resp.head_valid     = (count_q != '0);
  assign resp.head_rec       = mem[rptr_q];

  assign wr_en = credit.push & credit.credit_avail;
  assign rd_en = resp.pop & resp.head_valid;

  assign credit.ack_rec = wr_en;
  // Each accepted pop hands one credit back
  assign resp.free_pop  = rd_en;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wptr_q] <= credit.rec;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_en) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (rd_en) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Push and pop together leave the count unchanged
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb_obi_integrity_unit.sv
// Testbench for the OBI integrity unit
`timescale 1ns/1ps
`default_nettype none

module tb_obi_integrity_unit;

  localparam int NUM_TXN    = 14;
  localparam int WORDS      = 8;
  localparam int MAX_CYCLES = NUM_TXN * 10 + 50;
  // Inject codes in the last column of the stimulus file
  localparam int BAD_RCHK      = 1;
  localparam int BAD_GNTPAR    = 2;
  localparam int BAD_RVALIDPAR = 3;

  logic        clk_i = 1'b0;
  logic        rst;
  logic        core_req;
  logic        core_we;
  logic        core_dbg;
  logic [31:0] core_addr;
  logic [31:0] core_wdata;
  logic [3:0]  core_be;
  logic [2:0]  core_prot;
  logic [1:0]  core_memtype;
  logic        core_ready;
  logic        core_rvalid;
  logic [31:0] core_rdata;
  logic        core_err;
  logic        core_integrity_err;
  logic        obi_req;
  logic        obi_reqpar;
  logic [12:0] obi_achk;
  logic [31:0] obi_addr;
  logic [31:0] obi_wdata;
  logic [3:0]  obi_be;
  logic        obi_we;
  logic        obi_dbg;
  logic [2:0]  obi_prot;
  logic [1:0]  obi_memtype;
  logic        obi_gnt;
  logic        obi_gntpar;
  logic        obi_rvalid;
  logic        obi_rvalidpar;
  logic [31:0] obi_rdata;
  logic        obi_err;
  logic        obi_exokay;
  logic [4:0]  obi_rchk;
  logic        csr_we;
  logic        csr_wdata;
  logic        integrity_enabled;
  logic        alert_major;

  logic [31:0] stim [NUM_TXN*WORDS];
  logic        fault_now;
  logic        alert_exp;
  int          cycles = 0;

  obi_integrity_unit i_obi_integrity_unit (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [3:0] bytes_par(input logic [31:0] w);
    return {^w[31:24], ^w[23:16], ^w[15:8], ^w[7:0]};
  endfunction

  // Address phase checksum of the request on the core side, atop and mid are zero
  function automatic logic [12:0] achk_model();
    return {bytes_par(core_wdata), ~core_dbg, 1'b0, 1'b0, ~^{core_be, core_we},
            ~^{core_prot, core_memtype}, bytes_par(core_addr)};
  endfunction

  function automatic logic [4:0] rchk_model(input logic [31:0] rdata, input logic err,
                                            input logic exokay);
    return {err ^ exokay, bytes_par(rdata)};
  endfunction

  task automatic report_error(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first error");
  endtask

  // A fault in one cycle shows up as alert_major in the next
  always @(posedge clk_i) begin
    alert_exp <= rst ? 1'b0 : fault_now;
  end

  always @(negedge clk_i) begin
    if (!rst && obi_req) begin
      assert (obi_achk == achk_model())
        else report_error($sformatf("achk %h, expected %h", obi_achk, achk_model()));
      assert (obi_addr == core_addr && obi_wdata == core_wdata && obi_be == core_be &&
              obi_we == core_we && obi_dbg == core_dbg && obi_prot == core_prot &&
              obi_memtype == core_memtype)
        else report_error("address phase fields on the bus differ from the core request");
    end
    if (!rst) begin
      assert (alert_major == alert_exp)
        else report_error($sformatf("alert_major %b, expected %b", alert_major, alert_exp));
    end
    assert (!i_obi_integrity_unit.i_obi_integrity_unit_asserts.assert_failed)
      else report_error("a bound protocol assertion failed");
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run took more than %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  // One response cycle, called right after a rising edge
  task automatic respond(input logic [31:0] rdata, input logic err, input logic [4:0] rchk,
                         input logic bad_rvp, input logic fault, input logic exp_ierr);
    obi_rvalid    <= 1'b1;
    obi_rvalidpar <= bad_rvp;
    obi_rdata     <= rdata;
    obi_err       <= err;
    obi_rchk      <= rchk;
    fault_now     <= fault;
    @(negedge clk_i);
    assert (core_rvalid && core_rdata == rdata && core_err == err &&
            core_integrity_err == exp_ierr)
      else report_error($sformatf("response rdata %h err %b ierr %b, expected %h %b %b",
                                  core_rdata, core_err, core_integrity_err,
                                  rdata, err, exp_ierr));
    @(posedge clk_i);
    obi_rvalid    <= 1'b0;
    obi_rvalidpar <= 1'b1;
    fault_now     <= 1'b0;
  endtask

  task automatic run_txn(input int idx);
    logic [31:0] rdata;
    logic [4:0]  rchk;
    logic        is_store;
    logic        err;
    logic        en;
    logic        rchk_hit;
    int          inj;
    int          base;
    base     = idx * WORDS;
    is_store = stim[base][0];
    rdata    = stim[base+4];
    err      = stim[base+5][0];
    en       = stim[base+6][0];
    inj      = int'(stim[base+7]);
    // Enable is written one cycle ahead of the request
    @(posedge clk_i);
    csr_we    <= 1'b1;
    csr_wdata <= en;
    @(posedge clk_i);
    csr_we       <= 1'b0;
    core_req     <= 1'b1;
    core_we      <= is_store;
    core_addr    <= stim[base+1];
    core_wdata   <= stim[base+2];
    core_be      <= stim[base+3][3:0];
    core_dbg     <= idx[0];
    core_prot    <= idx[2:0];
    core_memtype <= idx[3:2];
    repeat ($urandom % 3) @(posedge clk_i);
    obi_gnt    <= 1'b1;
    obi_gntpar <= (inj == BAD_GNTPAR);
    fault_now  <= (inj == BAD_GNTPAR);
    @(negedge clk_i);
    assert (obi_req && core_ready) else report_error("request was not granted");
    assert (integrity_enabled == en)
      else report_error($sformatf("integrity_enabled %b, expected %b",
                                  integrity_enabled, en));
    @(posedge clk_i);
    core_req   <= 1'b0;
    obi_gnt    <= 1'b0;
    obi_gntpar <= 1'b1;
    fault_now  <= 1'b0;
    repeat ($urandom % 3) @(posedge clk_i);
    rchk = rchk_model(rdata, err, 1'b0);
    // Flipped data parity only counts for loads with checking on
    rchk_hit = (inj == BAD_RCHK) && en && !is_store;
    if (inj == BAD_RCHK) begin
      rchk[0] = ~rchk[0];
    end
    respond(rdata, err, rchk, inj == BAD_RVALIDPAR, rchk_hit || inj == BAD_RVALIDPAR,
            rchk_hit || inj == BAD_RVALIDPAR || inj == BAD_GNTPAR);
  endtask

  // Responses held back until both credits are used up
  task automatic check_backpressure();
    int grants;
    grants = 0;
    @(posedge clk_i);
    core_req   <= 1'b1;
    core_we    <= 1'b0;
    core_addr  <= 32'h0000_4000;
    obi_gnt    <= 1'b1;
    obi_gntpar <= 1'b0;
    repeat (6) begin
      @(negedge clk_i);
      if (obi_req) begin
        grants++;
      end
    end
    assert (grants == 2 && !core_ready)
      else report_error($sformatf("%0d requests granted with no response back", grants));
    @(posedge clk_i);
    core_req   <= 1'b0;
    obi_gnt    <= 1'b0;
    obi_gntpar <= 1'b1;
    respond(32'h600d_0001, 1'b0, rchk_model(32'h600d_0001, 1'b0, 1'b0), 1'b0, 1'b0, 1'b0);
    respond(32'h600d_0002, 1'b0, rchk_model(32'h600d_0002, 1'b0, 1'b0), 1'b0, 1'b0, 1'b0);
    core_req   <= 1'b1;
    obi_gnt    <= 1'b1;
    obi_gntpar <= 1'b0;
    @(negedge clk_i);
    assert (obi_req && core_ready) else report_error("no credit came back after the responses");
    @(posedge clk_i);
    core_req   <= 1'b0;
    obi_gnt    <= 1'b0;
    obi_gntpar <= 1'b1;
    respond(32'h600d_0003, 1'b1, rchk_model(32'h600d_0003, 1'b1, 1'b0), 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(26));
    $readmemh("obi_integrity_stim.txt", stim);
    rst           = 1'b1;
    core_req      = 1'b0;
    core_we       = 1'b0;
    core_dbg      = 1'b0;
    core_addr     = '0;
    core_wdata    = '0;
    core_be       = '0;
    core_prot     = '0;
    core_memtype  = '0;
    obi_gnt       = 1'b0;
    obi_gntpar    = 1'b1;
    obi_rvalid    = 1'b0;
    obi_rvalidpar = 1'b1;
    obi_rdata     = '0;
    obi_err       = 1'b0;
    obi_exokay    = 1'b0;
    obi_rchk      = '0;
    csr_we        = 1'b0;
    csr_wdata     = 1'b0;
    fault_now     = 1'b0;
    repeat (4) @(posedge clk_i);
    rst <= 1'b0;
    @(negedge clk_i);
    assert (integrity_enabled) else report_error("integrity_enabled is low after reset");
    for (int i = 0; i < NUM_TXN; i++) begin
      run_txn(i);
    end
    check_backpressure();
    repeat (2) @(posedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
